//--- tag_store_pkg.sv
// ====================
// Shared definitions for the LLC tag store
// Request mode encoding and the default configuration
// used by every module of the tag store
// ====================
`default_nettype none

package tag_store_pkg;

  // Request mode, one bit wide
  typedef enum logic {
    LOOKUP = 1'b0,
    FLUSH  = 1'b1
  } tag_mode_e;

  // Default set associativity
  localparam int unsigned DefNumWays    = 4;
  // Default lines per way
  localparam int unsigned DefNumLines   = 16;
  // Default tag width in bits
  localparam int unsigned DefTagWidth   = 8;
  // Default tag RAM read latency in cycles
  localparam int unsigned DefRamLatency = 1;

endpackage

`default_nettype wire

//--- tag_ram.sv
// ====================
// Tag memory of a single way
// Stores {valid, dirty, tag} per line, read data comes out after
// RamLatency cycles together with a read-valid token
// ====================
`timescale 1ns/1ps
`default_nettype none

module tag_ram import tag_store_pkg::*; #(
  parameter int unsigned NumLines   = DefNumLines,
  parameter int unsigned TagWidth   = DefTagWidth,
  parameter int unsigned RamLatency = DefRamLatency,
  localparam int unsigned IdxW      = (NumLines > 1) ? $clog2(NumLines) : 1,
  localparam int unsigned EntryW    = TagWidth + 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [IdxW-1:0]   index_i,
  input  logic [EntryW-1:0] wdata_i,
  output logic [EntryW-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [EntryW-1:0]     mem_q [NumLines];
  logic [EntryW-1:0]     data_q [RamLatency];
  logic [RamLatency-1:0] tok_q;
  logic                  rd_en;

  // Only reads launch a token
  assign rd_en = req_i & ~we_i;

  // Storage array, all lines invalid after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumLines; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  // Read pipeline, first stage holds until the next read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      data_q[0] <= mem_q[index_i];
    end
    for (int i = 1; i < RamLatency; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  // Token chain, matches the data pipeline depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tok_q <= '0;
    end else begin
      tok_q[0] <= rd_en;
      for (int i = 1; i < RamLatency; i++) begin
        tok_q[i] <= tok_q[i-1];
      end
    end
  end

  assign rdata_o  = data_q[RamLatency-1];
  assign rvalid_o = tok_q[RamLatency-1];

endmodule

`default_nettype wire

//--- tag_compare.sv
// ====================
// Tag compare across all ways
// Builds hit, valid and dirty vectors from the RAM read data and
// muxes out the entry of one selected way
// ====================
`timescale 1ns/1ps
`default_nettype none

module tag_compare import tag_store_pkg::*; #(
  parameter int unsigned NumWays  = DefNumWays,
  parameter int unsigned TagWidth = DefTagWidth,
  localparam int unsigned EntryW  = TagWidth + 2
) (
  input  logic [NumWays-1:0][EntryW-1:0] rdata_i,
  input  logic [TagWidth-1:0]            lookup_tag_i,
  input  logic [NumWays-1:0]             way_mask_i,
  input  logic [NumWays-1:0]             sel_way_i,
  output logic [NumWays-1:0]             hit_o,
  output logic [NumWays-1:0]             valid_o,
  output logic [NumWays-1:0]             dirty_o,
  output logic [TagWidth-1:0]            sel_tag_o,
  output logic                           sel_valid_o,
  output logic                           sel_dirty_o
);

  logic [NumWays-1:0] tag_eq;

  // Entry layout is {valid, dirty, tag}
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    assign valid_o[w] = rdata_i[w][EntryW-1];
    assign dirty_o[w] = rdata_i[w][EntryW-2];
    assign tag_eq[w]  = (rdata_i[w][TagWidth-1:0] == lookup_tag_i);
    // Disabled or invalid ways never hit
    assign hit_o[w]   = way_mask_i[w] & valid_o[w] & tag_eq[w];
  end

  // One-hot mux, an empty select gives all zero
  always_comb begin
    sel_tag_o   = '0;
    sel_valid_o = 1'b0;
    sel_dirty_o = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      sel_tag_o   = sel_tag_o | ({TagWidth{sel_way_i[w]}} & rdata_i[w][TagWidth-1:0]);
      sel_valid_o = sel_valid_o | (sel_way_i[w] & valid_o[w]);
      sel_dirty_o = sel_dirty_o | (sel_way_i[w] & dirty_o[w]);
    end
  end

endmodule

`default_nettype wire

//--- evict_select.sv
// ====================
// Victim way selection on a lookup miss
// Prefers free ways, otherwise rotates over the unlocked ways;
// the pointer advances on each committed miss
// ====================
`timescale 1ns/1ps
`default_nettype none

module evict_select import tag_store_pkg::*; #(
  parameter int unsigned NumWays = DefNumWays,
  localparam int unsigned PtrW   = (NumWays > 1) ? $clog2(NumWays) : 1
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [NumWays-1:0] valid_i,
  input  logic [NumWays-1:0] dirty_i,
  input  logic [NumWays-1:0] spm_lock_i,
  input  logic [NumWays-1:0] way_mask_i,
  input  logic               commit_i,
  output logic [NumWays-1:0] way_o,
  output logic               evict_o
);

  logic [NumWays-1:0] cand;
  logic [NumWays-1:0] free;
  logic [PtrW-1:0]    ptr_q;
  logic [PtrW-1:0]    ptr_d;
  logic [PtrW-1:0]    victim_idx;
  logic               found;

  // Locked ways act as scratchpad and are never replaced
  assign cand = way_mask_i & ~spm_lock_i;
  assign free = cand & ~valid_i;

  always_comb begin
    int unsigned idx;
    victim_idx = '0;
    found      = 1'b0;
    idx        = 0;
    if (|free) begin
      // Lowest free candidate wins
      found = 1'b1;
      for (int i = NumWays - 1; i >= 0; i--) begin
        if (free[i]) begin
          victim_idx = PtrW'(i);
        end
      end
    end else begin
      // First candidate at or after the pointer
      for (int i = 0; i < NumWays; i++) begin
        idx = ptr_q + i;
        if (idx >= NumWays) begin
          idx = idx - NumWays;
        end
        if (!found && cand[idx]) begin
          found      = 1'b1;
          victim_idx = PtrW'(idx);
        end
      end
    end
  end

  assign way_o   = found ? (NumWays'(1) << victim_idx) : '0;
  // A free way has nothing to write back
  assign evict_o = found & ~(|free) & dirty_i[victim_idx];

  // Next pointer is the way after the victim
  assign ptr_d = (victim_idx == PtrW'(NumWays - 1)) ? '0 : victim_idx + PtrW'(1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (commit_i && found) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

//--- tag_store_ctrl.sv
// ====================
// Tag store controller
// Accepts one request at a time, issues the RAM reads, assembles the
// response and writes the updated entry back on the response handshake
// ====================
`timescale 1ns/1ps
`default_nettype none

module tag_store_ctrl import tag_store_pkg::*; #(
  parameter int unsigned NumWays  = DefNumWays,
  parameter int unsigned NumLines = DefNumLines,
  parameter int unsigned TagWidth = DefTagWidth,
  localparam int unsigned IdxW    = (NumLines > 1) ? $clog2(NumLines) : 1,
  localparam int unsigned EntryW  = TagWidth + 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request side
  input  logic                valid_i,
  output logic                ready_o,
  input  tag_mode_e           mode_i,
  input  logic [NumWays-1:0]  way_mask_i,
  input  logic [IdxW-1:0]     index_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                dirty_i,
  // Response side
  output logic                valid_o,
  input  logic                ready_i,
  output logic [NumWays-1:0]  way_o,
  output logic                hit_o,
  output logic                evict_o,
  output logic [TagWidth-1:0] evict_tag_o,
  // Tag RAM access
  output logic [NumWays-1:0]  ram_req_o,
  output logic [NumWays-1:0]  ram_we_o,
  output logic [IdxW-1:0]     ram_index_o,
  output logic [EntryW-1:0]   ram_wdata_o,
  input  logic [NumWays-1:0]  rvalid_i,
  // Compare and victim results
  input  logic [NumWays-1:0]  hit_i,
  input  logic                sel_valid_i,
  input  logic                sel_dirty_i,
  input  logic [TagWidth-1:0] sel_tag_i,
  input  logic [NumWays-1:0]  victim_way_i,
  input  logic                victim_evict_i,
  output logic [NumWays-1:0]  sel_way_o,
  output logic                commit_o,
  // Held request fields for the compare stage
  output logic [NumWays-1:0]  req_mask_o,
  output logic [TagWidth-1:0] req_tag_o
);

  logic                busy_q;
  logic                busy_d;
  logic                rvalid_q;
  logic                load;
  logic                rsp_hs;
  logic                is_hit;
  tag_mode_e           mode_q;
  logic [NumWays-1:0]  mask_q;
  logic [IdxW-1:0]     index_q;
  logic [TagWidth-1:0] tag_q;
  logic                dirty_q;

  // Response waits for the latched read-valid
  assign valid_o = busy_q & rvalid_q;
  assign rsp_hs  = valid_o & ready_i;
  assign is_hit  = (mode_q == LOOKUP) & (|hit_i);

  // Reported way that also selects the entry muxed by the compare stage
  always_comb begin
    if (mode_q == FLUSH) begin
      sel_way_o = mask_q;
    end else if (is_hit) begin
      sel_way_o = hit_i;
    end else begin
      sel_way_o = victim_way_i;
    end
  end

  assign way_o       = sel_way_o;
  assign hit_o       = is_hit;
  assign evict_o     = (mode_q == FLUSH) ? (sel_valid_i & sel_dirty_i)
                                         : (~is_hit & victim_evict_i);
  assign evict_tag_o = is_hit ? '0 : sel_tag_i;

  assign req_mask_o = mask_q;
  assign req_tag_o  = tag_q;

  // RAM requests, busy control and write-back
  always_comb begin
    ready_o     = 1'b0;
    load        = 1'b0;
    busy_d      = busy_q;
    commit_o    = 1'b0;
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = index_q;
    ram_wdata_o = '0;
    if (!busy_q) begin
      ready_o = 1'b1;
      if (valid_i) begin
        load        = 1'b1;
        busy_d      = 1'b1;
        ram_req_o   = way_mask_i;
        ram_index_o = index_i;
      end
    end else if (rsp_hs) begin
      busy_d = 1'b0;
      case (mode_q)
        LOOKUP: begin
          if (!is_hit) begin
            // Miss installs the new tag in the victim
            ram_req_o   = victim_way_i;
            ram_we_o    = victim_way_i;
            ram_wdata_o = {1'b1, dirty_q, tag_q};
            commit_o    = 1'b1;
          end else if (dirty_q && !sel_dirty_i) begin
            // Hit on a clean line that now becomes dirty
            ram_req_o   = hit_i;
            ram_we_o    = hit_i;
            ram_wdata_o = {1'b1, 1'b1, tag_q};
          end else if (valid_i && (mode_i == LOOKUP)) begin
            // Clean hit overlaps the next lookup
            ready_o     = 1'b1;
            load        = 1'b1;
            busy_d      = 1'b1;
            ram_req_o   = way_mask_i;
            ram_index_o = index_i;
          end
        end
        FLUSH: begin
          // Clear the flushed entry
          ram_req_o = mask_q;
          ram_we_o  = mask_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
      mode_q   <= LOOKUP;
    end else begin
      busy_q <= busy_d;
      // Read result stays valid until the response is taken
      if (rsp_hs) begin
        rvalid_q <= 1'b0;
      end else if (|rvalid_i) begin
        rvalid_q <= 1'b1;
      end
      if (load) begin
        mode_q <= mode_i;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      mask_q  <= way_mask_i;
      index_q <= index_i;
      tag_q   <= tag_i;
      dirty_q <= dirty_i;
    end
  end

endmodule

`default_nettype wire

//--- tag_store.sv
// ====================
// LLC tag store top level
// Lookup and flush requests in, one response per request out,
// both over valid/ready; spm_lock_i keeps ways out of replacement
// ====================
`timescale 1ns/1ps
`default_nettype none

module tag_store import tag_store_pkg::*; #(
  parameter int unsigned NumWays    = DefNumWays,
  parameter int unsigned NumLines   = DefNumLines,
  parameter int unsigned TagWidth   = DefTagWidth,
  parameter int unsigned RamLatency = DefRamLatency,
  localparam int unsigned IdxW      = (NumLines > 1) ? $clog2(NumLines) : 1,
  localparam int unsigned EntryW    = TagWidth + 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  output logic                ready_o,
  input  tag_mode_e           mode_i,
  input  logic [NumWays-1:0]  way_mask_i,
  input  logic [IdxW-1:0]     index_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                dirty_i,
  input  logic [NumWays-1:0]  spm_lock_i,
  output logic                valid_o,
  input  logic                ready_i,
  output logic [NumWays-1:0]  way_o,
  output logic                hit_o,
  output logic                evict_o,
  output logic [TagWidth-1:0] evict_tag_o
);

  logic [NumWays-1:0]             ram_req;
  logic [NumWays-1:0]             ram_we;
  logic [IdxW-1:0]                ram_index;
  logic [EntryW-1:0]              ram_wdata;
  logic [NumWays-1:0][EntryW-1:0] ram_rdata;
  logic [NumWays-1:0]             ram_rvalid;
  logic [NumWays-1:0]             hit;
  logic [NumWays-1:0]             tag_valid;
  logic [NumWays-1:0]             tag_dirty;
  logic [NumWays-1:0]             sel_way;
  logic [TagWidth-1:0]            sel_tag;
  logic                           sel_valid;
  logic                           sel_dirty;
  logic [NumWays-1:0]             victim_way;
  logic                           victim_evict;
  logic                           commit;
  logic [NumWays-1:0]             req_mask;
  logic [TagWidth-1:0]            req_tag;

  tag_store_ctrl #(
    .NumWays  (NumWays),
    .NumLines (NumLines),
    .TagWidth (TagWidth)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .mode_i         (mode_i),
    .way_mask_i     (way_mask_i),
    .index_i        (index_i),
    .tag_i          (tag_i),
    .dirty_i        (dirty_i),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .way_o          (way_o),
    .hit_o          (hit_o),
    .evict_o        (evict_o),
    .evict_tag_o    (evict_tag_o),
    .ram_req_o      (ram_req),
    .ram_we_o       (ram_we),
    .ram_index_o    (ram_index),
    .ram_wdata_o    (ram_wdata),
    .rvalid_i       (ram_rvalid),
    .hit_i          (hit),
    .sel_valid_i    (sel_valid),
    .sel_dirty_i    (sel_dirty),
    .sel_tag_i      (sel_tag),
    .victim_way_i   (victim_way),
    .victim_evict_i (victim_evict),
    .sel_way_o      (sel_way),
    .commit_o       (commit),
    .req_mask_o     (req_mask),
    .req_tag_o      (req_tag)
  );

  // One tag memory per way, sharing index and write data
  for (genvar w = 0; w < NumWays; w++) begin : gen_ram
    tag_ram #(
      .NumLines   (NumLines),
      .TagWidth   (TagWidth),
      .RamLatency (RamLatency)
    ) u_tag_ram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (ram_req[w]),
      .we_i     (ram_we[w]),
      .index_i  (ram_index),
      .wdata_i  (ram_wdata),
      .rdata_o  (ram_rdata[w]),
      .rvalid_o (ram_rvalid[w])
    );
  end

  tag_compare #(
    .NumWays  (NumWays),
    .TagWidth (TagWidth)
  ) u_compare (
    .rdata_i      (ram_rdata),
    .lookup_tag_i (req_tag),
    .way_mask_i   (req_mask),
    .sel_way_i    (sel_way),
    .hit_o        (hit),
    .valid_o      (tag_valid),
    .dirty_o      (tag_dirty),
    .sel_tag_o    (sel_tag),
    .sel_valid_o  (sel_valid),
    .sel_dirty_o  (sel_dirty)
  );

  evict_select #(
    .NumWays (NumWays)
  ) u_evict (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (tag_valid),
    .dirty_i    (tag_dirty),
    .spm_lock_i (spm_lock_i),
    .way_mask_i (req_mask),
    .commit_i   (commit),
    .way_o      (victim_way),
    .evict_o    (victim_evict)
  );

endmodule

`default_nettype wire

//--- tag_store_chk.sv
// ====================
// Protocol assertions for the tag store,
// attached to the top level by bind
// ====================
`timescale 1ns/1ps
`default_nettype none

module tag_store_chk import tag_store_pkg::*; #(
  parameter int unsigned NumWays  = DefNumWays,
  parameter int unsigned TagWidth = DefTagWidth
) (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                valid_i,
  input logic                ready_o,
  input tag_mode_e           mode_i,
  input logic [NumWays-1:0]  spm_lock_i,
  input logic                valid_o,
  input logic                ready_i,
  input logic [NumWays-1:0]  way_o,
  input logic                hit_o,
  input logic                evict_o,
  input logic [TagWidth-1:0] evict_tag_o
);

  tag_mode_e mode_q;

  // Mode of the request in flight
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q <= LOOKUP;
    end else if (valid_i && ready_o) begin
      mode_q <= mode_i;
    end
  end

  way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $onehot(way_o))
    else $error("way_o not one-hot on a response");

  // Stalled response keeps every field
  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(way_o) && $stable(hit_o)
                               && $stable(evict_o) && $stable(evict_tag_o)))
    else $error("response changed under back-pressure");

  no_accept_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |-> !ready_o)
    else $error("request side ready while a response waits");

  victim_unlocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !hit_o && mode_q == LOOKUP) |-> ((way_o & spm_lock_i) == '0))
    else $error("miss victim is a locked way");

endmodule

`default_nettype wire

//--- tb_tag_store.sv
// ====================
// Testbench for the LLC tag store
// Directed lookups, flushes and lock cases, then random traffic with
// ready_i stalls; every response is checked against a reference model
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_tag_store;
  import tag_store_pkg::*;

  localparam int NW = DefNumWays;
  localparam int NL = DefNumLines;
  localparam int TW = DefTagWidth;
  localparam int RL = DefRamLatency;
  localparam int IW = $clog2(DefNumLines);
  localparam int ReqW = NW + IW + TW + 2;
  localparam int MaxCycles = 4000;
  localparam logic [31:0] Seed = 32'haba7_800b;

  logic clk_i;
  logic rst_n_i;
  logic valid_i;
  logic ready_o;
  tag_mode_e mode_i;
  logic [NW-1:0] way_mask_i;
  logic [IW-1:0] index_i;
  logic [TW-1:0] tag_i;
  logic dirty_i;
  logic [NW-1:0] spm_lock_i;
  logic valid_o;
  logic ready_i;
  logic [NW-1:0] way_o;
  logic hit_o;
  logic evict_o;
  logic [TW-1:0] evict_tag_o;

  // Reference state per way and line and the victim pointer
  logic m_valid [NW][NL];
  logic m_dirty [NW][NL];
  logic [TW-1:0] m_tag [NW][NL];
  int vptr;
  // Accepted requests waiting for their response
  logic [ReqW-1:0] pend_q [$];
  // Edges since the last accepted request until its response shows up
  int rsp_age;
  logic [31:0] req_state;
  logic [31:0] gap_state;
  int cycles;

  tag_store #(
    .NumWays    (NW),
    .NumLines   (NL),
    .TagWidth   (TW),
    .RamLatency (RL)
  ) UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .mode_i      (mode_i),
    .way_mask_i  (way_mask_i),
    .index_i     (index_i),
    .tag_i       (tag_i),
    .dirty_i     (dirty_i),
    .spm_lock_i  (spm_lock_i),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .way_o       (way_o),
    .hit_o       (hit_o),
    .evict_o     (evict_o),
    .evict_tag_o (evict_tag_o)
  );

  // Protocol checks on the top level
  bind tag_store tag_store_chk #(
    .NumWays  (NumWays),
    .TagWidth (TagWidth)
  ) u_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .mode_i      (mode_i),
    .spm_lock_i  (spm_lock_i),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .way_o       (way_o),
    .hit_o       (hit_o),
    .evict_o     (evict_o),
    .evict_tag_o (evict_tag_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Model gives the expected response and then takes the update
  task automatic model_apply(input tag_mode_e mode, input logic [NW-1:0] mask,
                             input logic [IW-1:0] idx, input logic [TW-1:0] tag,
                             input logic dirty, output logic [NW-1:0] e_way,
                             output logic e_hit, output logic e_evict,
                             output logic [TW-1:0] e_tag, output logic e_write);
    logic [NW-1:0] hitv;
    logic [NW-1:0] cand;
    logic [NW-1:0] free;
    int v;
    hitv = '0;
    free = '0;
    v = -1;
    for (int w = 0; w < NW; w++) begin
      hitv[w] = mask[w] && m_valid[w][idx] && (m_tag[w][idx] == tag);
    end
    if (mode == FLUSH) begin
      for (int w = 0; w < NW; w++) begin
        if (mask[w]) v = w;
      end
      e_way = mask;
      e_hit = 1'b0;
      e_evict = m_valid[v][idx] & m_dirty[v][idx];
      e_tag = m_tag[v][idx];
      e_write = 1'b1;
      m_valid[v][idx] = 1'b0;
      m_dirty[v][idx] = 1'b0;
      m_tag[v][idx] = '0;
    end else if (hitv != '0) begin
      e_way = hitv;
      e_hit = 1'b1;
      e_evict = 1'b0;
      e_tag = '0;
      e_write = 1'b0;
      for (int w = 0; w < NW; w++) begin
        if (hitv[w] && dirty) begin
          e_write = e_write | ~m_dirty[w][idx];
          m_dirty[w][idx] = 1'b1;
        end
      end
    end else begin
      cand = mask & ~spm_lock_i;
      for (int w = 0; w < NW; w++) begin
        free[w] = cand[w] & ~m_valid[w][idx];
      end
      if (free != '0) begin
        // Lowest free candidate has nothing to write back
        for (int w = NW - 1; w >= 0; w--) begin
          if (free[w]) v = w;
        end
        e_evict = 1'b0;
      end else begin
        for (int k = 0; k < NW; k++) begin
          if (v < 0 && cand[(vptr + k) % NW]) v = (vptr + k) % NW;
        end
        e_evict = m_dirty[v][idx];
      end
      e_way = NW'(1) << v;
      e_hit = 1'b0;
      e_tag = m_tag[v][idx];
      e_write = 1'b1;
      m_valid[v][idx] = 1'b1;
      m_dirty[v][idx] = dirty;
      m_tag[v][idx] = tag;
      vptr = (v + 1) % NW;
    end
  endtask

  task automatic check_response();
    logic mode_b;
    logic [NW-1:0] mask;
    logic [IW-1:0] idx;
    logic [TW-1:0] tag;
    logic dirty;
    logic [NW-1:0] e_way;
    logic e_hit;
    logic e_evict;
    logic [TW-1:0] e_tag;
    logic e_write;
    logic e_rdy;
    if (pend_q.size() == 0) begin
      stop_run("Response arrived with no request outstanding");
    end else begin
      {mode_b, mask, idx, tag, dirty} = pend_q.pop_front();
      model_apply(tag_mode_e'(mode_b), mask, idx, tag, dirty, e_way, e_hit, e_evict, e_tag,
                  e_write);
      assert (way_o == e_way) else report_mismatch("way_o", 32'(way_o), 32'(e_way));
      assert (hit_o == e_hit) else report_mismatch("hit_o", 32'(hit_o), 32'(e_hit));
      assert (evict_o == e_evict) else report_mismatch("evict_o", 32'(evict_o), 32'(e_evict));
      assert (evict_tag_o == e_tag)
        else report_mismatch("evict_tag_o", 32'(evict_tag_o), 32'(e_tag));
      // A waiting lookup is taken at once when the response needs no write
      if (valid_i) begin
        e_rdy = !e_write && (mode_i == LOOKUP);
        assert (ready_o == e_rdy) else report_mismatch("ready_o", 32'(ready_o), 32'(e_rdy));
      end
    end
  endtask

  // Response check comes before the capture of a request taken at the same edge
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Idle store takes a request at once
      if (pend_q.size() == 0) begin
        assert (ready_o) else report_mismatch("ready_o", 32'(ready_o), 32'h1);
      end
      // Response rises a fixed number of edges after acceptance
      if (rsp_age >= 0) begin
        rsp_age = rsp_age + 1;
        assert (valid_o == (rsp_age > RL))
          else report_mismatch("valid_o", 32'(valid_o), 32'(rsp_age > RL));
        if (valid_o) rsp_age = -1;
      end
      if (valid_o && ready_i) check_response();
      if (valid_i && ready_o) begin
        pend_q.push_back({mode_i, way_mask_i, index_i, tag_i, dirty_i});
        rsp_age = 0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      stop_run($sformatf("Timeout: the run did not finish within %0d cycles", MaxCycles));
    end
  end

  // Response back-pressure with ready low about one cycle in four
  always @(negedge clk_i) begin
    gap_state = xorshift32(gap_state);
    ready_i = (gap_state[1:0] != 2'b00);
  end

  task automatic send_req(input tag_mode_e mode, input logic [NW-1:0] mask,
                          input logic [IW-1:0] idx, input logic [TW-1:0] tag,
                          input logic dirty);
    @(negedge clk_i);
    valid_i = 1'b1;
    mode_i = mode;
    way_mask_i = mask;
    index_i = idx;
    tag_i = tag;
    dirty_i = dirty;
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    valid_i = 1'b0;
    while (pend_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic lookup_all(input logic [IW-1:0] idx, input logic [TW-1:0] tag,
                            input logic dirty);
    send_req(LOOKUP, '1, idx, tag, dirty);
    wait_idle();
  endtask

  // Random mask widened to every way that already holds the tag
  function automatic logic [NW-1:0] lookup_mask(input logic [IW-1:0] idx,
                                                input logic [TW-1:0] tag,
                                                input logic [NW-1:0] rnd);
    logic [NW-1:0] m;
    m = rnd;
    for (int w = 0; w < NW; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == tag) m[w] = 1'b1;
    end
    if ((m & ~spm_lock_i) == '0) m = m | ~spm_lock_i;
    return m;
  endfunction

  initial begin
    logic [NW-1:0] mask;
    logic [IW-1:0] idx;
    logic [TW-1:0] tag;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    mode_i = LOOKUP;
    way_mask_i = '0;
    index_i = '0;
    tag_i = '0;
    dirty_i = 1'b0;
    spm_lock_i = 4'b0001;
    ready_i = 1'b0;
    cycles = 0;
    vptr = 0;
    rsp_age = -1;
    req_state = Seed;
    gap_state = {Seed[15:0], Seed[31:16]};
    for (int w = 0; w < NW; w++) begin
      for (int l = 0; l < NL; l++) begin
        m_valid[w][l] = 1'b0;
        m_dirty[w][l] = 1'b0;
        m_tag[w][l] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // Empty set miss and then a hit on the same line
    lookup_all(4'd3, 8'h11, 1'b0);
    lookup_all(4'd3, 8'h11, 1'b0);
    // Fill all unlocked ways dirty and force a pointer victim
    lookup_all(4'd5, 8'h21, 1'b1);
    lookup_all(4'd5, 8'h22, 1'b1);
    lookup_all(4'd5, 8'h23, 1'b1);
    lookup_all(4'd5, 8'h24, 1'b0);
    // Flush a dirty line whose tag misses afterwards
    send_req(FLUSH, 4'b0100, 4'd5, 8'h00, 1'b0);
    wait_idle();
    lookup_all(4'd5, 8'h22, 1'b0);
    // Two locked ways so misses rotate over the other two
    spm_lock_i = 4'b0110;
    for (int t = 0; t < 6; t++) begin
      lookup_all(4'd7, TW'(8'h31 + t), 1'b1);
    end
    // Random traffic with back-to-back lookup bursts
    spm_lock_i = 4'b0100;
    repeat (150) begin
      req_state = xorshift32(req_state);
      idx = IW'(req_state[2:0]);
      tag = TW'(req_state[7:4]);
      if (req_state[10:8] == 3'd0) begin
        send_req(FLUSH, NW'(1) << req_state[12:11], idx, '0, 1'b0);
      end else begin
        mask = lookup_mask(idx, tag, req_state[18:15]);
        send_req(LOOKUP, mask, idx, tag, req_state[13]);
        if (req_state[14]) begin
          send_req(LOOKUP, mask, idx, tag, 1'b0);
          send_req(LOOKUP, mask, idx, tag, 1'b0);
        end
      end
      wait_idle();
    end
    repeat (2) @(negedge clk_i);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tag_store.f
tag_store_pkg.sv
tag_ram.sv
tag_compare.sv
evict_select.sv
tag_store_ctrl.sv
tag_store.sv
tag_store_chk.sv
tb_tag_store.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_tag_store \
  -f tag_store.f -Mdir obj_dir &&
./obj_dir/Vtb_tag_store | tee /dev/stderr | grep -q "^Test passed$" &&
echo "simulation ok" || { echo "simulation FAILED"; exit 1; }
